/* src/vid_config.svh */
`ifndef VID_CONFIG_SVH
`define VID_CONFIG_SVH

// counter and span width for lines up to 8191 pixels
`define VID_CNT_W       13

// host register word and pixel word
`define VID_WORD_W      32
`define VID_ADDR_W      8

// pixel FIFO geometry
`define VID_FIFO_DEPTH  32
`define VID_FIFO_AW     5 // log2 of the depth

// register map on an 8-byte stride
`define VID_REG_CTRL    8'h00
`define VID_REG_HSPAN   8'h28 // h_size / h_end
`define VID_REG_HSYNC   8'h30 // hsync start / end
`define VID_REG_VSPAN   8'h38 // v_size / v_end
`define VID_REG_VSYNC   8'h40 // vsync start / end

`endif

/* src/vid_pkg.sv */
`include "vid_config.svh"

package vid_pkg;

    // codes 2 and 3 are reserved and shown as rgb24
    typedef enum logic [1:0] {
        MODE_RGB24  = 2'd0,
        MODE_RGB565 = 2'd1,
        MODE_RSVD2  = 2'd2,
        MODE_RSVD3  = 2'd3
    } color_mode_e;

    // pclk sits in bits 9:4 and enable in bit 3 with mode in bits 1:0
    typedef struct packed {
        logic [21:0]  spare;
        logic [5:0]   pclk;     // clocks per pixel, 0 acts as 1
        logic         enable;
        logic         rsvd;
        color_mode_e  mode;
    } ctrl_word_t;

    // two spans per word with first in [25:13] and second in [12:0]
    typedef struct packed {
        logic [`VID_WORD_W-2*`VID_CNT_W-1:0] spare;
        logic [`VID_CNT_W-1:0]               first;
        logic [`VID_CNT_W-1:0]               second;
    } span_word_t;

    typedef union packed {
        ctrl_word_t ctrl;
        span_word_t span;
    } reg_word_u;

    typedef struct packed {
        logic [5:0]            pclk;
        logic                  enable;
        color_mode_e           mode;
        logic [`VID_CNT_W-1:0] h_size;
        logic [`VID_CNT_W-1:0] h_end;
        logic [`VID_CNT_W-1:0] hsync_start;
        logic [`VID_CNT_W-1:0] hsync_end;
        logic [`VID_CNT_W-1:0] v_size;
        logic [`VID_CNT_W-1:0] v_end;
        logic [`VID_CNT_W-1:0] vsync_start;
        logic [`VID_CNT_W-1:0] vsync_end;
    } vid_cfg_t;

    typedef struct packed {
        logic slot_start;   // first clock of a pixel slot
        logic active;
        logic hsync;
        logic vsync;
    } vid_tick_t;

endpackage

/* src/vid_regs.sv */
`timescale 1ns/1ps
`include "vid_config.svh"

module vid_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   reg_wr,
    input  logic [`VID_ADDR_W-1:0] reg_addr,
    input  vid_pkg::reg_word_u     reg_data,
    output vid_pkg::vid_cfg_t      cfg
);

    // the address picks which view of the write word is meaningful
    // the control register uses the ctrl view and the four span
    // registers each split the word into two 13-bit fields

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                `VID_REG_CTRL: begin
                    cfg.pclk   <= reg_data.ctrl.pclk;
                    cfg.enable <= reg_data.ctrl.enable;
                    cfg.mode   <= reg_data.ctrl.mode;
                end
                `VID_REG_HSPAN: begin
                    cfg.h_size <= reg_data.span.first;  // visible pixels
                    cfg.h_end  <= reg_data.span.second; // last hcnt of line
                end
                `VID_REG_HSYNC: begin
                    cfg.hsync_start <= reg_data.span.first;
                    cfg.hsync_end   <= reg_data.span.second;
                end
                `VID_REG_VSPAN: begin
                    cfg.v_size <= reg_data.span.first;
                    cfg.v_end  <= reg_data.span.second;
                end
                `VID_REG_VSYNC: begin
                    cfg.vsync_start <= reg_data.span.first;
                    cfg.vsync_end   <= reg_data.span.second;
                end
                default: begin
                    // unknown address, write dropped
                end
            endcase
        end
    end

endmodule

/* src/vid_timing.sv */
`timescale 1ns/1ps
`include "vid_config.svh"

module vid_timing (
    input  logic              clk,
    input  logic              reset,
    input  vid_pkg::vid_cfg_t cfg,
    output vid_pkg::vid_tick_t tick
);

    logic [5:0]            div_cnt;    // clock index inside the pixel slot
    logic [5:0]            slot_last;
    logic                  slot_end;
    logic [`VID_CNT_W-1:0] hcnt;
    logic [`VID_CNT_W-1:0] vcnt;

    // pclk of 0 behaves as 1, so the slot is always at least one clock
    assign slot_last = (cfg.pclk == 6'd0) ? 6'd0 : cfg.pclk - 6'd1;

    // >= rather than == so a smaller pclk written mid-slot cannot stall
    assign slot_end = (div_cnt >= slot_last);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_cnt <= '0;
            hcnt    <= '0;
            vcnt    <= '0;
        end else if (!cfg.enable) begin
            div_cnt <= '0;       // park at the top-left corner
            hcnt    <= '0;
            vcnt    <= '0;
        end else if (slot_end) begin
            div_cnt <= '0;
            if (hcnt >= cfg.h_end) begin
                hcnt <= '0;
                if (vcnt >= cfg.v_end) begin
                    vcnt <= '0;
                end else begin
                    vcnt <= vcnt + 1'b1;
                end
            end else begin
                hcnt <= hcnt + 1'b1;
            end
        end else begin
            div_cnt <= div_cnt + 6'd1;
        end
    end

    // all tick bits come straight from the counters; pixel_out does the
    // output registering
    always_comb begin
        tick = '0;
        if (cfg.enable) begin
            tick.slot_start = (div_cnt == 6'd0);
            tick.active     = (hcnt < cfg.h_size) && (vcnt < cfg.v_size);
            tick.hsync      = (hcnt >= cfg.hsync_start) && (hcnt < cfg.hsync_end);
            tick.vsync      = (vcnt >= cfg.vsync_start) && (vcnt < cfg.vsync_end);
        end
    end

endmodule

/* src/pixel_fifo.sv */
`timescale 1ns/1ps
`include "vid_config.svh"

module pixel_fifo (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push,
    input  logic [`VID_WORD_W-1:0] push_data,
    input  logic                   pop,
    output logic [`VID_WORD_W-1:0] head,
    output logic                   empty,
    output logic                   full
);

    logic [`VID_WORD_W-1:0] mem [`VID_FIFO_DEPTH];
    logic [`VID_FIFO_AW-1:0] wr_ptr;
    logic [`VID_FIFO_AW-1:0] rd_ptr;
    logic [`VID_FIFO_AW:0]   count;   // one extra bit to tell full from empty
    logic                    push_ok;
    logic                    pop_ok;

    assign push_ok = push && !full; // a push into a full FIFO is lost
    assign pop_ok  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == (`VID_FIFO_AW+1)'(`VID_FIFO_DEPTH));

    // show-ahead so the oldest word is on head before the pop
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps by itself as the depth is a power of two
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* src/pixel_out.sv */
`timescale 1ns/1ps
`include "vid_config.svh"

module pixel_out (
    input  logic                   clk,
    input  logic                   reset,
    input  vid_pkg::vid_tick_t     tick,
    input  vid_pkg::color_mode_e   mode,
    input  logic [`VID_WORD_W-1:0] head,
    input  logic                   empty,
    output logic                   pop,
    output logic                   hsync,
    output logic                   vsync,
    output logic                   blank,
    output logic [7:0]             r,
    output logic [7:0]             g,
    output logic [7:0]             b,
    output logic                   underrun
);

    import vid_pkg::*;

    logic [`VID_WORD_W-1:0] hold_word;   // pixel of the current slot
    logic [`VID_WORD_W-1:0] next_word;
    logic [`VID_WORD_W-1:0] cur_word;
    logic                   starve;
    logic [7:0]             r_dec;
    logic [7:0]             g_dec;
    logic [7:0]             b_dec;

    assign starve = tick.slot_start && tick.active && empty;
    assign pop    = tick.slot_start && tick.active && !empty;

    // an empty FIFO gives a zero word, which is black in both modes
    assign next_word = pop ? head : '0;
    assign cur_word  = tick.slot_start ? next_word : hold_word;

    always_ff @(posedge clk) begin
        if (tick.slot_start) begin
            hold_word <= next_word;
        end
    end

    always_comb begin
        case (mode)
            MODE_RGB565: begin
                r_dec = {cur_word[15:11], 3'b000};
                g_dec = {cur_word[10:5], 2'b00};
                b_dec = {cur_word[4:0], 3'b000};
            end
            default: begin  // rgb24 and both reserved codes
                r_dec = cur_word[23:16];
                g_dec = cur_word[15:8];
                b_dec = cur_word[7:0];
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hsync    <= 1'b0;
            vsync    <= 1'b0;
            blank    <= 1'b1;
            r        <= '0;
            g        <= '0;
            b        <= '0;
            underrun <= 1'b0;
        end else begin
            hsync    <= tick.hsync;
            vsync    <= tick.vsync;
            blank    <= !tick.active;
            r        <= tick.active ? r_dec : 8'd0;
            g        <= tick.active ? g_dec : 8'd0;
            b        <= tick.active ? b_dec : 8'd0;
            underrun <= underrun || starve;   // sticky until reset
        end
    end

endmodule

/* src/vid_top.sv */
`timescale 1ns/1ps
`include "vid_config.svh"

module vid_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   reg_wr,
    input  logic [`VID_ADDR_W-1:0] reg_addr,
    input  vid_pkg::reg_word_u     reg_data,
    input  logic                   pix_wr,
    input  logic [`VID_WORD_W-1:0] pix_data,
    output logic                   pix_full,
    output logic                   hsync,
    output logic                   vsync,
    output logic                   blank,
    output logic [7:0]             r,
    output logic [7:0]             g,
    output logic [7:0]             b,
    output logic                   underrun
);

    import vid_pkg::*;

    vid_cfg_t               cfg;
    vid_tick_t              tick;
    logic [`VID_WORD_W-1:0] fifo_head;
    logic                   fifo_empty;
    logic                   fifo_pop;

    vid_regs u_regs (
        .clk      (clk),
        .reset    (reset),
        .reg_wr   (reg_wr),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .cfg      (cfg)
    );

    vid_timing u_timing (
        .clk   (clk),
        .reset (reset),
        .cfg   (cfg),
        .tick  (tick)
    );

    pixel_fifo u_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (pix_wr),
        .push_data (pix_data),
        .pop       (fifo_pop),
        .head      (fifo_head),
        .empty     (fifo_empty),
        .full      (pix_full)
    );

    pixel_out u_out (
        .clk      (clk),
        .reset    (reset),
        .tick     (tick),
        .mode     (cfg.mode),
        .head     (fifo_head),
        .empty    (fifo_empty),
        .pop      (fifo_pop),
        .hsync    (hsync),
        .vsync    (vsync),
        .blank    (blank),
        .r        (r),
        .g        (g),
        .b        (b),
        .underrun (underrun)
    );

endmodule

/* tb/tb_vid.sv */
`timescale 1ns/1ps
`include "vid_config.svh"

module tb_vid;

    import vid_pkg::*;

    localparam int TIMEOUT   = 2000;   // cycles allowed for any single wait
    localparam int SEL_BLANK = 0;
    localparam int SEL_HSYNC = 1;
    localparam int SEL_VSYNC = 2;
    // small test mode
    localparam int H_SIZE    = 8;
    localparam int H_END     = 11;
    localparam int HS_START  = 9;
    localparam int HS_END    = 11;
    localparam int V_SIZE    = 4;
    localparam int V_END     = 6;
    localparam int VS_START  = 5;
    localparam int VS_END    = 6;
    localparam int PCLK      = 2;

    logic                   clk;
    logic                   reset;
    logic                   reg_wr;
    logic [`VID_ADDR_W-1:0] reg_addr;
    reg_word_u              reg_data;
    logic                   pix_wr;
    logic [`VID_WORD_W-1:0] pix_data;
    logic                   pix_full;
    logic                   hsync;
    logic                   vsync;
    logic                   blank;
    logic [7:0]             r;
    logic [7:0]             g;
    logic [7:0]             b;
    logic                   underrun;

    logic [15:0]            lfsr;
    logic [31:0]            pushed [$];   // words in the FIFO with the oldest first
    int                     errors;
    int                     tests_run;
    int                     tests_bad;

    vid_top dut (
        .clk      (clk),
        .reset    (reset),
        .reg_wr   (reg_wr),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .pix_wr   (pix_wr),
        .pix_data (pix_data),
        .pix_full (pix_full),
        .hsync    (hsync),
        .vsync    (vsync),
        .blank    (blank),
        .r        (r),
        .g        (g),
        .b        (b),
        .underrun (underrun)
    );

    always #10 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic probe(input int sel);
        case (sel)
            SEL_BLANK: return blank;
            SEL_HSYNC: return hsync;
            default:   return vsync;
        endcase
    endfunction

    function automatic string sig_name(input int sel);
        case (sel)
            SEL_BLANK: return "blank";
            SEL_HSYNC: return "hsync";
            default:   return "vsync";
        endcase
    endfunction

    // rgb24 takes the low three bytes and 565 pads each field with zeros
    function automatic logic [23:0] expect_rgb(input logic [31:0] w, input logic m565);
        if (m565) begin
            return {w[15:11], 3'b000, w[10:5], 2'b00, w[4:0], 3'b000};
        end
        return w[23:0];
    endfunction

    task automatic step();
        @(posedge clk);
        #1;   // drive and sample just after the edge
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_level(input int sel, input logic val);
        int n;
        n = 0;
        while (probe(sel) !== val && n < TIMEOUT) begin
            step();
            n++;
        end
        assert (probe(sel) === val) else begin
            $display("%0t ns: %s never went to %0d", $time, sig_name(sel), val);
            errors++;
        end
    endtask

    task automatic run_length(input int sel, input logic val, output int len);
        len = 0;
        while (probe(sel) === val && len < TIMEOUT) begin
            len++;
            step();
        end
        assert (len < TIMEOUT) else begin
            $display("%0t ns: %s stuck at %0d", $time, sig_name(sel), val);
            errors++;
        end
    endtask

    task automatic rand_word(output logic [31:0] w);
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            w[i] = lfsr[0];
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (16) step();
        reset = 1'b0;
        step();
        pushed.delete();
    endtask

    task automatic write_reg(input logic [7:0] addr, input reg_word_u word);
        reg_wr   = 1'b1;
        reg_addr = addr;
        reg_data = word;
        step();
        reg_wr   = 1'b0;
    endtask

    task automatic write_span(input logic [7:0] addr, input logic [12:0] first,
                              input logic [12:0] second);
        reg_word_u w;
        w            = '0;
        w.span.first  = first;
        w.span.second = second;
        write_reg(addr, w);
    endtask

    task automatic write_ctrl(input logic [5:0] pclk, input logic en, input color_mode_e mode);
        reg_word_u w;
        w             = '0;
        w.ctrl.pclk   = pclk;
        w.ctrl.enable = en;
        w.ctrl.mode   = mode;
        write_reg(`VID_REG_CTRL, w);
    endtask

    task automatic set_small_mode();
        write_span(`VID_REG_HSPAN, 13'(H_SIZE), 13'(H_END));
        write_span(`VID_REG_HSYNC, 13'(HS_START), 13'(HS_END));
        write_span(`VID_REG_VSPAN, 13'(V_SIZE), 13'(V_END));
        write_span(`VID_REG_VSYNC, 13'(VS_START), 13'(VS_END));
    endtask

    task automatic drive_pixel(input logic [31:0] w);
        pix_wr   = 1'b1;
        pix_data = w;
        step();
        pix_wr   = 1'b0;
    endtask

    task automatic push_random(input int n);
        logic [31:0] w;
        repeat (n) begin
            rand_word(w);
            drive_pixel(w);
            pushed.push_back(w);
        end
    endtask

    // n visible pixels in push order with each held for hold cycles
    task automatic check_pixels(input logic m565, input int hold, input int n);
        logic [31:0] w;
        for (int k = 0; k < n; k++) begin
            wait_level(SEL_BLANK, 1'b0);
            w = pushed.pop_front();
            for (int c = 0; c < hold; c++) begin
                check_val("blank", 32'(blank), 32'd0);
                check_val("rgb", {8'h00, r, g, b}, {8'h00, expect_rgb(w, m565)});
                step();
            end
        end
    endtask

    task automatic report(input string name, input int start);
        tests_run++;
        if (errors == start) begin
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - start);
        end
    endtask

    task automatic test_reset_state();
        int start;
        start = errors;
        apply_reset();
        repeat (100) begin
            check_val("blank", 32'(blank), 32'd1);
            check_val("hsync", 32'(hsync), 32'd0);
            check_val("vsync", 32'(vsync), 32'd0);
            check_val("rgb", {8'h00, r, g, b}, 32'd0);
            check_val("underrun", 32'(underrun), 32'd0);
            step();
        end
        report("reset_state", start);
    endtask

    task automatic test_line_timing();
        int start;
        int len;
        int high;
        int low;
        start = errors;
        apply_reset();
        set_small_mode();
        write_ctrl(6'(PCLK), 1'b1, MODE_RGB24);
        wait_level(SEL_VSYNC, 1'b1);   // line up on the top of the next frame
        wait_level(SEL_VSYNC, 1'b0);
        for (int ln = 0; ln < V_SIZE; ln++) begin
            wait_level(SEL_BLANK, 1'b0);
            run_length(SEL_BLANK, 1'b0, len);
            check_val("active cycles", len, H_SIZE * PCLK);
        end
        wait_level(SEL_HSYNC, 1'b0);
        wait_level(SEL_HSYNC, 1'b1);
        run_length(SEL_HSYNC, 1'b1, high);
        run_length(SEL_HSYNC, 1'b0, low);
        check_val("hsync width", high, (HS_END - HS_START) * PCLK);
        check_val("hsync period", high + low, (H_END + 1) * PCLK);
        wait_level(SEL_VSYNC, 1'b0);
        wait_level(SEL_VSYNC, 1'b1);
        run_length(SEL_VSYNC, 1'b1, len);
        check_val("vsync width", len, (VS_END - VS_START) * (H_END + 1) * PCLK);
        report("line_timing", start);
    endtask

    task automatic test_rgb24();
        int start;
        start = errors;
        apply_reset();
        set_small_mode();
        push_random(24);   // enough for three lines without underrun
        write_ctrl(6'(PCLK), 1'b1, MODE_RGB24);
        check_pixels(1'b0, PCLK, 24);
        check_val("underrun", 32'(underrun), 32'd0);
        report("rgb24", start);
    endtask

    task automatic test_rgb565();
        int start;
        start = errors;
        apply_reset();
        set_small_mode();
        push_random(20);
        write_ctrl(6'd0, 1'b1, MODE_RGB565);   // pclk 0 runs as 1
        check_pixels(1'b1, 1, 20);
        report("rgb565", start);
    endtask

    task automatic test_underrun();
        int start;
        start = errors;
        apply_reset();
        set_small_mode();
        push_random(3);
        write_ctrl(6'(PCLK), 1'b1, MODE_RGB24);
        check_val("underrun", 32'(underrun), 32'd0);
        check_pixels(1'b0, PCLK, 3);
        repeat ((H_SIZE - 3) * PCLK) begin   // rest of the line is starved
            check_val("blank", 32'(blank), 32'd0);
            check_val("rgb", {8'h00, r, g, b}, 32'd0);
            check_val("underrun", 32'(underrun), 32'd1);
            step();
        end
        repeat (100) begin
            check_val("underrun", 32'(underrun), 32'd1);
            step();
        end
        report("underrun", start);
    endtask

    task automatic test_full_flag();
        int start;
        logic [31:0] extra;
        start = errors;
        apply_reset();
        set_small_mode();
        push_random(`VID_FIFO_DEPTH);
        check_val("pix_full", 32'(pix_full), 32'd1);
        rand_word(extra);
        drive_pixel(extra | 32'h0080_8080);   // nonzero in every byte and dropped
        check_val("pix_full", 32'(pix_full), 32'd1);
        write_ctrl(6'd1, 1'b1, MODE_RGB24);
        check_pixels(1'b0, 1, `VID_FIFO_DEPTH);
        wait_level(SEL_BLANK, 1'b0);
        repeat (H_SIZE) begin
            check_val("rgb", {8'h00, r, g, b}, 32'd0);
            step();
        end
        report("full_flag", start);
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        reg_wr    = 1'b0;
        reg_addr  = '0;
        reg_data  = '0;
        pix_wr    = 1'b0;
        pix_data  = '0;
        lfsr      = 16'd82;
        errors    = 0;
        tests_run = 0;
        tests_bad = 0;

        test_reset_state();
        test_line_timing();
        test_rgb24();
        test_rgb565();
        test_underrun();
        test_full_flag();

        $display("%0d tests run, %0d with errors, %0d check errors",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+src
src/vid_pkg.sv
src/vid_regs.sv
src/vid_timing.sv
src/pixel_fifo.sv
src/pixel_out.sv
src/vid_top.sv
tb/tb_vid.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -f list.f --top-module tb_vid

out=$(./obj_dir/Vtb_vid)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
